/* hdl/lsBufferDefs_defs.svh */
`ifndef LS_BUFFER_DEFS_SVH
`define LS_BUFFER_DEFS_SVH

// Buffer geometry
`define LS_DEPTH      8
`define LS_DATA_W     32
`define LS_TAG_W      4
`define LS_MEM_WORDS  64
`define LS_OP_W       4

// Bit 3 is the store flag, bit 2 the unsigned flag, bits 1..0 the size
`define LS_OP_LB      4'b0000
`define LS_OP_LH      4'b0001
`define LS_OP_LW      4'b0010
`define LS_OP_NOP     4'b0011 // Size 3 has no access and marks an empty slot
`define LS_OP_LBU     4'b0100
`define LS_OP_LHU     4'b0101
`define LS_OP_SB      4'b1000
`define LS_OP_SH      4'b1001
`define LS_OP_SW      4'b1010

`define LS_SIZE_BYTE  2'd0
`define LS_SIZE_HALF  2'd1
`define LS_SIZE_WORD  2'd2

`define LS_TAG_NONE   4'd0

`endif

/* hdl/lsBufferPkg.sv */
`include "lsBufferDefs_defs.svh"

package lsBufferPkg;

    // Decoded view of the memory operation word
    typedef struct packed {
        logic       isStore;
        logic       unsignedLoad;
        logic [1:0] size;        // 0 byte, 1 half, 2 word
    } lsOpFields_s;

    // One word seen either as a raw code or as its decoded fields
    typedef union packed {
        logic [`LS_OP_W-1:0] code;
        lsOpFields_s         f;
    } lsOpWord_u;

endpackage

/* hdl/lsAllocator.sv */
`timescale 1ns/100ps
`include "lsBufferDefs_defs.svh"

module lsAllocator
    import lsBufferPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispValid,
    input  lsOpWord_u            opWord,
    output logic                 dispReady,
    input  logic                 freeValid,
    output logic [`LS_DEPTH-1:0] allocEn
);
    localparam int PtrW = $clog2(`LS_DEPTH);

    logic [PtrW-1:0] tail;
    logic [PtrW:0]   count;
    logic            doAlloc;

    assign dispReady = (count < `LS_DEPTH);

    // NOP is still accepted so the dispatcher moves on
    assign doAlloc = dispValid && dispReady && (opWord.code != `LS_OP_NOP);

    always_comb begin
        allocEn = '0;
        if (doAlloc) begin
            allocEn[tail] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (doAlloc) begin
                tail <= (tail == PtrW'(`LS_DEPTH - 1)) ? '0 : tail + 1'b1; // Circular fill
            end
            case ({doAlloc, freeValid})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // Both or neither leave it alone
            endcase
        end
    end

endmodule

/* hdl/lsBufLine.sv */
`timescale 1ns/100ps
`include "lsBufferDefs_defs.svh"

module lsBufLine
    import lsBufferPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 allocEn,
    input  logic                 free,
    input  logic [`LS_DATA_W-1:0] baseVal,
    input  logic [`LS_TAG_W-1:0]  baseTag,
    input  logic [`LS_DATA_W-1:0] storeVal,
    input  logic [`LS_TAG_W-1:0]  storeTag,
    input  logic [`LS_DATA_W-1:0] offset,
    input  logic [`LS_TAG_W-1:0]  dstTag,
    input  lsOpWord_u             opWord,
    input  logic                  aluCdbValid,
    input  logic [`LS_TAG_W-1:0]  aluCdbTag,
    input  logic [`LS_DATA_W-1:0] aluCdbData,
    input  logic                  lsCdbFire,
    input  logic [`LS_TAG_W-1:0]  lsCdbTag,
    input  logic [`LS_DATA_W-1:0] lsCdbData,
    output logic                  lineReady,
    output logic [`LS_DATA_W-1:0] base,
    output logic [`LS_DATA_W-1:0] storeData,
    output logic [`LS_DATA_W-1:0] lineOffset,
    output logic [`LS_TAG_W-1:0]  lineDstTag,
    output lsOpWord_u             lineOp
);
    logic                  occupied;
    logic [`LS_TAG_W-1:0]  baseTagQ;
    logic [`LS_TAG_W-1:0]  storeTagQ;
    logic [`LS_TAG_W-1:0]  srcBaseTag, srcStoreTag;
    logic [`LS_DATA_W-1:0] srcBase, srcStore;
    logic                  baseAluHit, baseLsHit, storeAluHit, storeLsHit;
    logic [`LS_DATA_W-1:0] baseNext, storeNext;
    logic [`LS_TAG_W-1:0]  baseTagNext, storeTagNext;

    function automatic logic busHit(input logic valid, input logic [`LS_TAG_W-1:0] busTag,
                                    input logic [`LS_TAG_W-1:0] waitTag);
        return valid && (waitTag != `LS_TAG_NONE) && (busTag == waitTag);
    endfunction

    // A broadcast in the dispatch cycle is caught on the incoming operand
    assign srcBaseTag  = allocEn ? baseTag  : baseTagQ;
    assign srcBase     = allocEn ? baseVal  : base;
    assign srcStoreTag = allocEn ? storeTag : storeTagQ;
    assign srcStore    = allocEn ? storeVal : storeData;

    assign baseAluHit  = busHit(aluCdbValid, aluCdbTag, srcBaseTag);
    assign baseLsHit   = busHit(lsCdbFire, lsCdbTag, srcBaseTag);
    assign storeAluHit = busHit(aluCdbValid, aluCdbTag, srcStoreTag);
    assign storeLsHit  = busHit(lsCdbFire, lsCdbTag, srcStoreTag);

    // ALU bus wins when both carry the tag
    assign baseNext     = baseAluHit ? aluCdbData : (baseLsHit ? lsCdbData : srcBase);
    assign baseTagNext  = (baseAluHit || baseLsHit) ? `LS_TAG_NONE : srcBaseTag;
    assign storeNext    = storeAluHit ? aluCdbData : (storeLsHit ? lsCdbData : srcStore);
    assign storeTagNext = (storeAluHit || storeLsHit) ? `LS_TAG_NONE : srcStoreTag;

    assign lineReady = occupied && (baseTagQ == `LS_TAG_NONE) && (storeTagQ == `LS_TAG_NONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied <= 1'b0;
        end else if (allocEn) begin
            occupied <= 1'b1;
        end else if (free) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn || occupied) begin
            base      <= baseNext;
            baseTagQ  <= baseTagNext;
            storeData <= storeNext;
            storeTagQ <= storeTagNext;
        end
        if (allocEn) begin
            lineOffset <= offset;
            lineDstTag <= dstTag;
            lineOp     <= opWord;
        end
    end

endmodule

/* hdl/lsIssue.sv */
`timescale 1ns/100ps
`include "lsBufferDefs_defs.svh"

module lsIssue
    import lsBufferPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`LS_DEPTH-1:0]  lineReady,
    input  logic [`LS_DATA_W-1:0] lineBase      [`LS_DEPTH],
    input  logic [`LS_DATA_W-1:0] lineStoreData [`LS_DEPTH],
    input  logic [`LS_DATA_W-1:0] lineOffset    [`LS_DEPTH],
    input  logic [`LS_TAG_W-1:0]  lineDstTag    [`LS_DEPTH],
    input  lsOpWord_u             lineOp        [`LS_DEPTH],
    output logic [`LS_DEPTH-1:0]  lineFree,
    output logic                  freeValid,
    output logic                  reqValid,
    input  logic                  reqReady,
    output logic [`LS_DATA_W-1:0] reqBase,
    output logic [`LS_DATA_W-1:0] reqStoreData,
    output logic [`LS_DATA_W-1:0] reqOffset,
    output logic [`LS_TAG_W-1:0]  reqDstTag,
    output lsOpWord_u             reqOp
);
    localparam int PtrW = $clog2(`LS_DEPTH);

    logic [PtrW-1:0] head;
    logic [PtrW-1:0] headInc;
    logic [PtrW-1:0] loadIdx;
    logic            reqFire;
    logic            loadReq;

    assign reqFire = reqValid && reqReady;
    assign headInc = (head == PtrW'(`LS_DEPTH - 1)) ? '0 : head + 1'b1;

    // On acceptance the next line in order may load in the same cycle
    assign loadIdx = reqFire ? headInc : head;
    assign loadReq = (!reqValid || reqReady) && lineReady[loadIdx];

    // The request register keeps the fields, so the line is released here
    always_comb begin
        lineFree = '0;
        if (reqFire) begin
            lineFree[head] = 1'b1;
        end
    end

    assign freeValid = reqFire;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head     <= '0;
            reqValid <= 1'b0;
        end else begin
            if (reqFire) begin
                head <= headInc;
            end
            if (loadReq) begin
                reqValid <= 1'b1;
            end else if (reqFire) begin
                reqValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadReq) begin
            reqBase      <= lineBase[loadIdx];
            reqStoreData <= lineStoreData[loadIdx];
            reqOffset    <= lineOffset[loadIdx];
            reqDstTag    <= lineDstTag[loadIdx];
            reqOp        <= lineOp[loadIdx];
        end
    end

endmodule

/* hdl/lsMemUnit.sv */
`timescale 1ns/100ps
`include "lsBufferDefs_defs.svh"

module lsMemUnit
    import lsBufferPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  reqValid,
    output logic                  reqReady,
    input  logic [`LS_DATA_W-1:0] reqBase,
    input  logic [`LS_DATA_W-1:0] reqStoreData,
    input  logic [`LS_DATA_W-1:0] reqOffset,
    input  logic [`LS_TAG_W-1:0]  reqDstTag,
    input  lsOpWord_u             reqOp,
    output logic                  lsCdbValid,
    input  logic                  lsCdbReady,
    output logic [`LS_TAG_W-1:0]  lsCdbTag,
    output logic [`LS_DATA_W-1:0] lsCdbData
);
    localparam int IdxW = $clog2(`LS_MEM_WORDS);

    logic [`LS_DATA_W-1:0] mem [`LS_MEM_WORDS];
    logic [`LS_DATA_W-1:0] effAddr;
    logic [IdxW-1:0]       wordIdx;
    logic [1:0]            lane;
    logic [`LS_DATA_W-1:0] memWord;
    logic [3:0]            byteEn;
    logic [`LS_DATA_W-1:0] storeLanes;
    logic [7:0]            loadByte;
    logic [15:0]           loadHalf;
    logic [`LS_DATA_W-1:0] loadData;
    logic                  reqFire, storeFire, loadFire;

    // Stall only while a finished load still waits for the result bus
    assign reqReady  = !lsCdbValid || lsCdbReady;
    assign reqFire   = reqValid && reqReady;
    assign storeFire = reqFire && reqOp.f.isStore;
    assign loadFire  = reqFire && !reqOp.f.isStore;

    assign effAddr = reqBase + reqOffset;
    assign wordIdx = effAddr[2 +: IdxW];
    assign lane    = effAddr[1:0];
    assign memWord = mem[wordIdx];

    always_comb begin
        case (reqOp.f.size)
            `LS_SIZE_BYTE: begin
                byteEn     = 4'b0001 << lane;
                storeLanes = {4{reqStoreData[7:0]}};
            end
            `LS_SIZE_HALF: begin
                byteEn     = lane[1] ? 4'b1100 : 4'b0011;
                storeLanes = {2{reqStoreData[15:0]}};
            end
            default: begin
                byteEn     = 4'b1111;
                storeLanes = reqStoreData;
            end
        endcase
    end

    assign loadByte = memWord[{lane, 3'b000} +: 8];
    assign loadHalf = lane[1] ? memWord[31:16] : memWord[15:0];

    always_comb begin
        case (reqOp.f.size)
            `LS_SIZE_BYTE: loadData = reqOp.f.unsignedLoad ? {24'd0, loadByte}
                                                           : {{24{loadByte[7]}}, loadByte};
            `LS_SIZE_HALF: loadData = reqOp.f.unsignedLoad ? {16'd0, loadHalf}
                                                           : {{16{loadHalf[15]}}, loadHalf};
            default:       loadData = memWord;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `LS_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (storeFire) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[wordIdx][b*8 +: 8] <= storeLanes[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lsCdbValid <= 1'b0;
        end else if (loadFire) begin
            lsCdbValid <= 1'b1;
        end else if (lsCdbReady) begin
            lsCdbValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (loadFire) begin
            lsCdbTag  <= reqDstTag;
            lsCdbData <= loadData;
        end
    end

endmodule

/* hdl/lsBuffer.sv */
`timescale 1ns/100ps
`include "lsBufferDefs_defs.svh"

module lsBuffer
    import lsBufferPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispValid,
    output logic                  dispReady,
    input  logic [`LS_DATA_W-1:0] baseVal,
    input  logic [`LS_TAG_W-1:0]  baseTag,
    input  logic [`LS_DATA_W-1:0] storeVal,
    input  logic [`LS_TAG_W-1:0]  storeTag,
    input  logic [`LS_DATA_W-1:0] offset,
    input  logic [`LS_TAG_W-1:0]  dstTag,
    input  lsOpWord_u             opWord,
    input  logic                  aluCdbValid,
    input  logic [`LS_TAG_W-1:0]  aluCdbTag,
    input  logic [`LS_DATA_W-1:0] aluCdbData,
    output logic                  lsCdbValid,
    input  logic                  lsCdbReady,
    output logic [`LS_TAG_W-1:0]  lsCdbTag,
    output logic [`LS_DATA_W-1:0] lsCdbData
);
    logic [`LS_DEPTH-1:0]  allocEn;
    logic [`LS_DEPTH-1:0]  lineFree;
    logic [`LS_DEPTH-1:0]  lineReady;
    logic                  freeValid;
    logic                  lsCdbFire;
    logic [`LS_DATA_W-1:0] lineBase      [`LS_DEPTH];
    logic [`LS_DATA_W-1:0] lineStoreData [`LS_DEPTH];
    logic [`LS_DATA_W-1:0] lineOffset    [`LS_DEPTH];
    logic [`LS_TAG_W-1:0]  lineDstTag    [`LS_DEPTH];
    lsOpWord_u             lineOp        [`LS_DEPTH];
    logic                  reqValid, reqReady;
    logic [`LS_DATA_W-1:0] reqBase, reqStoreData, reqOffset;
    logic [`LS_TAG_W-1:0]  reqDstTag;
    lsOpWord_u             reqOp;

    assign lsCdbFire = lsCdbValid && lsCdbReady; // Lines snoop only completed transfers

    lsAllocator uAlloc (
        .clk(clk), .rst(rst), .dispValid(dispValid), .opWord(opWord),
        .dispReady(dispReady), .freeValid(freeValid), .allocEn(allocEn)
    );

    for (genvar i = 0; i < `LS_DEPTH; i++) begin : gLine
        lsBufLine uLine (
            .clk(clk), .rst(rst), .allocEn(allocEn[i]), .free(lineFree[i]),
            .baseVal(baseVal), .baseTag(baseTag), .storeVal(storeVal), .storeTag(storeTag),
            .offset(offset), .dstTag(dstTag), .opWord(opWord),
            .aluCdbValid(aluCdbValid), .aluCdbTag(aluCdbTag), .aluCdbData(aluCdbData),
            .lsCdbFire(lsCdbFire), .lsCdbTag(lsCdbTag), .lsCdbData(lsCdbData),
            .lineReady(lineReady[i]), .base(lineBase[i]), .storeData(lineStoreData[i]),
            .lineOffset(lineOffset[i]), .lineDstTag(lineDstTag[i]), .lineOp(lineOp[i])
        );
    end

    lsIssue uIssue (
        .clk(clk), .rst(rst), .lineReady(lineReady),
        .lineBase(lineBase), .lineStoreData(lineStoreData), .lineOffset(lineOffset),
        .lineDstTag(lineDstTag), .lineOp(lineOp),
        .lineFree(lineFree), .freeValid(freeValid),
        .reqValid(reqValid), .reqReady(reqReady), .reqBase(reqBase),
        .reqStoreData(reqStoreData), .reqOffset(reqOffset), .reqDstTag(reqDstTag),
        .reqOp(reqOp)
    );

    lsMemUnit uMem (
        .clk(clk), .rst(rst), .reqValid(reqValid), .reqReady(reqReady),
        .reqBase(reqBase), .reqStoreData(reqStoreData), .reqOffset(reqOffset),
        .reqDstTag(reqDstTag), .reqOp(reqOp),
        .lsCdbValid(lsCdbValid), .lsCdbReady(lsCdbReady),
        .lsCdbTag(lsCdbTag), .lsCdbData(lsCdbData)
    );

endmodule

/* verif/lsBuffer_assert.sv */
`timescale 1ns/100ps
`include "lsBufferDefs_defs.svh"

module lsBufferAssert (
    input logic                        clk,
    input logic                        rst,
    input logic                        dispValid,
    input logic                        dispReady,
    input logic [`LS_OP_W-1:0]         opWord,
    input logic                        reqValid,
    input logic                        reqReady,
    input logic                        lsCdbValid,
    input logic                        lsCdbReady,
    input logic [`LS_TAG_W-1:0]        lsCdbTag,
    input logic [`LS_DATA_W-1:0]       lsCdbData
);
    int failCount = 0;
    int lineCount;
    logic takesLine, leavesLine;

    // Lines in use, counted from the dispatch and issue handshakes
    assign takesLine  = dispValid && dispReady && (opWord != `LS_OP_NOP);
    assign leavesLine = reqValid && reqReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lineCount <= 0;
        end else begin
            lineCount <= lineCount + int'(takesLine) - int'(leavesLine);
        end
    end

    // A result stalled by the bus stays put until it is taken
    aHeld: assert property (@(posedge clk) disable iff (rst)
        lsCdbValid && !lsCdbReady |=> lsCdbValid && $stable(lsCdbTag) && $stable(lsCdbData))
        else begin
            $error("lsCdb result changed or dropped while lsCdbReady was low");
            failCount++;
        end

    aReset: assert property (@(posedge clk) rst |-> !reqValid && !lsCdbValid)
        else begin
            $error("reqValid or lsCdbValid high during reset");
            failCount++;
        end

    aFull: assert property (@(posedge clk) disable iff (rst)
        lineCount >= `LS_DEPTH |-> !dispReady)
        else begin
            $error("dispReady high with every buffer line occupied");
            failCount++;
        end

endmodule

bind lsBuffer lsBufferAssert uAssert (
    .clk(clk), .rst(rst), .dispValid(dispValid), .dispReady(dispReady), .opWord(opWord),
    .reqValid(reqValid), .reqReady(reqReady), .lsCdbValid(lsCdbValid),
    .lsCdbReady(lsCdbReady), .lsCdbTag(lsCdbTag), .lsCdbData(lsCdbData)
);

/* verif/lsBufferTb.sv */
`timescale 1ns/100ps
`include "lsBufferDefs_defs.svh"

module lsBufferTb
    import lsBufferPkg::*;
();
    logic clk, rst, dispValid, dispReady, aluCdbValid, lsCdbValid, lsCdbReady;
    logic [`LS_DATA_W-1:0] baseVal, storeVal, offset, aluCdbData, lsCdbData;
    logic [`LS_TAG_W-1:0] baseTag, storeTag, dstTag, aluCdbTag, lsCdbTag;
    lsOpWord_u opWord;
    logic [31:0] rngState = 32'h2febb69e;
    logic [7:0] refMem [256];
    logic [35:0] expQ [$]; // Tag and data of each expected load result, in program order
    logic [31:0] pendVal [16];
    logic [15:0] pendBusy, pendArmed;
    logic [3:0] mixOps [9] = '{`LS_OP_LB, `LS_OP_LBU, `LS_OP_LH, `LS_OP_LHU, `LS_OP_LW,
                               `LS_OP_SB, `LS_OP_SH, `LS_OP_SW, `LS_OP_NOP};
    int readyPct, errors, testErrs, passCount, failCount, tBase, tStore, waitCnt;
    bit timedOut;
    string testName;

    lsBuffer DUT (.*);

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // Little-endian byte memory, aligned down to the access size
    function automatic logic [31:0] refAccess(input lsOpWord_u op, input logic [7:0] a,
                                             input logic [31:0] sd);
        int n;
        logic [31:0] v;
        n = 1 << op.f.size;
        a = a & 8'(~(n - 1));
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (op.f.isStore) refMem[a + i] = sd[8*i +: 8];
            v[8*i +: 8] = refMem[a + i];
        end
        if (!op.f.unsignedLoad && n == 1) v = {{24{v[7]}}, v[7:0]};
        if (!op.f.unsignedLoad && n == 2) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    function automatic int freeTag(); // ALU tags live in 8..15, load tags in 1..7
        for (int t = 8; t < 16; t++) begin
            if (!pendBusy[t]) return t;
        end
        return 0;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Result bus readiness and ALU broadcasts of operands already in the buffer
    always @(negedge clk) begin
        int t;
        lsCdbReady = (xorshift() % 100) < readyPct;
        aluCdbValid = 1'b0;
        t = 8 + xorshift() % 8;
        if (pendArmed[t] && xorshift() % 2) begin
            aluCdbValid = 1'b1;
            aluCdbTag = 4'(t);
            aluCdbData = pendVal[t];
            pendArmed[t] = 1'b0;
            pendBusy[t] = 1'b0;
        end
    end

    always @(negedge clk) begin
        #5; // Inputs and registered outputs are settled here until the next rising edge
        if (!rst && lsCdbValid && lsCdbReady) begin
            assert (expQ.size() > 0) else begin
                $display("%s: a result with tag %0d arrived that nobody expected", testName,
                         lsCdbTag);
                errors++;
            end
            if (expQ.size() > 0) begin
                assert ({lsCdbTag, lsCdbData} == expQ[0]) else begin
                    $display("[FAIL] %s expected %h actual %h", testName, expQ[0],
                             {lsCdbTag, lsCdbData});
                    errors++;
                end
                void'(expQ.pop_front());
            end
        end
    end

    // Called at a falling edge; b and sd are the final operand values even when tagged
    task automatic sendOp(input logic [3:0] code, input logic [31:0] b, input logic [3:0] bt,
                          input logic [31:0] sd, input logic [3:0] st, input logic [31:0] off,
                          input logic [3:0] dt);
        lsOpWord_u op;
        logic [31:0] r;
        if (timedOut) return;
        op.code = code;
        if (code != `LS_OP_NOP) begin
            r = refAccess(op, 8'(b + off), sd);
            if (!op.f.isStore) expQ.push_back({dt, r});
        end
        if (bt >= 8) {pendVal[bt], pendBusy[bt]} = {b, 1'b1};
        if (st >= 8) {pendVal[st], pendBusy[st]} = {sd, 1'b1};
        {dispValid, opWord, baseTag, storeTag, offset, dstTag} = {1'b1, op, bt, st, off, dt};
        baseVal = bt ? xorshift() : b;
        storeVal = st ? xorshift() : sd;
        waitCnt = 0;
        #1;
        while (!dispReady) begin
            if (++waitCnt > 2000) begin
                $display("%s: timed out waiting for the buffer to accept an operation", testName);
                {timedOut, dispValid} = 2'b10;
                errors++;
                return;
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        dispValid = 1'b0;
        if (bt >= 8) pendArmed[bt] = 1'b1;
        if (st >= 8) pendArmed[st] = 1'b1;
    endtask

    task automatic waitDrained();
        waitCnt = 0;
        while ((expQ.size() > 0 || pendBusy != 0) && !timedOut) begin
            @(negedge clk);
            if (++waitCnt > 4000) begin
                $display("%s: timed out waiting for the expected results to drain", testName);
                timedOut = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic finishTest();
        waitDrained();
        if (errors == testErrs) passCount++;
        else failCount++;
        $display("Test %s: %s", testName, (errors == testErrs) ? "ok" : "failed");
    endtask

    task automatic startTest(input string name, input int pct);
        testName = name;
        testErrs = errors;
        readyPct = pct;
    endtask

    initial begin
        {rst, dispValid, aluCdbValid, lsCdbReady} = 4'b1001;
        {baseVal, storeVal, offset, aluCdbData} = '0;
        {baseTag, storeTag, dstTag, aluCdbTag} = '0;
        opWord = '0;
        {pendBusy, pendArmed, readyPct, errors, passCount, failCount, timedOut} = '0;
        readyPct = 100;
        foreach (refMem[i]) refMem[i] = 8'h00;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        startTest("resetState", 100);
        assert (dispReady && !lsCdbValid) else begin
            $display("resetState: dispReady low or lsCdbValid high after reset");
            errors++;
        end
        for (int i = 0; i < 64; i++) sendOp(`LS_OP_LW, i * 4, 0, 0, 0, 0, 1 + i % 7);
        finishTest();
        startTest("storeLoadSizes", 100);
        repeat (40) begin
            tBase = xorshift();
            sendOp(mixOps[5 + xorshift() % 3], tBase, 0, xorshift(), 0, xorshift() % 8, 0);
            sendOp(mixOps[xorshift() % 5], tBase, 0, 0, 0, xorshift() % 8, 1 + xorshift() % 7);
        end
        finishTest();
        startTest("tagWaiting", 60);
        repeat (6) begin
            tBase = freeTag();
            sendOp(`LS_OP_LW, xorshift(), 4'(tBase), 0, 0, 0, 2);
            tStore = freeTag();
            tBase = xorshift();
            sendOp(`LS_OP_SW, tBase, 0, xorshift(), 4'(tStore), 4, 0);
            sendOp(`LS_OP_LW, tBase, 0, 0, 0, 4, 3);
            sendOp(`LS_OP_LW, expQ[$][31:0], 3, 0, 0, 0, 5); // Base from the memory bus
            waitDrained(); // Tag 3 is back to idle before the next chain reuses it
        end
        finishTest();
        startTest("programOrder", 100);
        repeat (10) begin
            sendOp(`LS_OP_LHU, xorshift(), 4'(freeTag()), 0, 0, 2, 6);
            sendOp(`LS_OP_LB, xorshift(), 0, 0, 0, 1, 7);
        end
        finishTest();
        startTest("fullBuffer", 0);
        @(negedge clk);
        repeat (9) sendOp(`LS_OP_LW, xorshift(), 0, 0, 0, 0, 1 + xorshift() % 7);
        waitCnt = 0;
        while (dispReady && !timedOut && waitCnt < 20) begin
            @(negedge clk);
            waitCnt++;
        end
        assert (!dispReady) else begin
            $display("fullBuffer: dispReady stayed high with eight lines occupied");
            errors++;
        end
        readyPct = 40;
        finishTest();
        startTest("randomMix", 70);
        repeat (300) begin
            tBase = (xorshift() % 4 == 0) ? freeTag() : 0;
            pendBusy[tBase] = (tBase != 0) ? 1'b1 : 1'b0; // Reserve it before the second pick
            tStore = (xorshift() % 4 == 0) ? freeTag() : 0;
            sendOp(mixOps[xorshift() % 9], xorshift(), 4'(tBase), xorshift(), 4'(tStore),
                   xorshift() % 16, 1 + xorshift() % 7);
        end
        finishTest();
        errors += DUT.uAssert.failCount;
        $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errors);
        if (errors == 0 && !timedOut) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* lsBuffer.f */
+incdir+hdl
hdl/lsBufferPkg.sv
hdl/lsAllocator.sv
hdl/lsBufLine.sv
hdl/lsIssue.sv
hdl/lsMemUnit.sv
hdl/lsBuffer.sv
verif/lsBuffer_assert.sv
verif/lsBufferTb.sv

/* Bender.yml */
package:
  name: lsBuffer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsBufferPkg.sv
      - hdl/lsAllocator.sv
      - hdl/lsBufLine.sv
      - hdl/lsIssue.sv
      - hdl/lsMemUnit.sv
      - hdl/lsBuffer.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/lsBuffer_assert.sv
      - verif/lsBufferTb.sv
